// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_program_loader \
    -Mdir obj_dir -o sim_program_loader

status=0
./obj_dir/sim_program_loader > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "^NO ERRORS$" sim.log; then
    echo "Simulation passed."
    exit 0
fi
echo "Simulation failed."
exit 1

// ==== src/byte_word_assembler.sv ====
module byte_word_assembler (
    input  logic                          i_clock,        // System clock.
    input  logic                          i_reset,        // Synchronous reset, active high.
    input  logic                          i_load_enable,  // High while the host sends a program.
    input  logic [imem_pkg::NB_BYTE-1:0]  i_rx_byte,      // Byte from the host.
    input  logic                          i_rx_valid,     // One-cycle strobe for i_rx_byte.
    output logic [imem_pkg::NB_DATA-1:0]  o_word_data,    // Assembled big-endian word.
    output logic                          o_word_next     // Pulses once a word is complete.
);

    logic                                 load_enable_q;  // Load enable delayed by one cycle.
    logic                                 load_start;     // First cycle of a new load.
    logic                                 byte_accept;    // A byte is taken this cycle.
    logic                                 last_byte;      // The current byte closes a word.
    logic [imem_pkg::NB_BYTE_COUNT-1:0]   byte_count;     // Bytes already held for this word.

    // A rising edge of load enable starts a fresh program at byte zero.
    assign load_start  = i_load_enable && !load_enable_q;

    // Bytes outside a load window, or in its opening cycle, are dropped.
    assign byte_accept = i_rx_valid && i_load_enable && !load_start;

    assign last_byte   = (byte_count == imem_pkg::LAST_BYTE_INDEX); // Fourth byte of the word.

    // Control state for the load window and the byte position.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            load_enable_q <= 1'b0;                        // No load in progress after reset.
            byte_count    <= '0;                          // Start at the most significant byte.
            o_word_next   <= 1'b0;                        // No word pending.
        end else begin
            load_enable_q <= i_load_enable;               // Track the level for edge detection.
            o_word_next   <= byte_accept && last_byte;    // Pulse in the cycle after byte four.
            if (!i_load_enable || load_start) begin
                byte_count <= '0;                         // Realign to a word boundary.
            end else if (byte_accept) begin
                byte_count <= byte_count + 1'b1;          // Wraps from 3 back to 0.
            end
        end
    end

    // Shift register for the word payload, the first byte ends up on top.
    always_ff @(posedge i_clock) begin
        if (byte_accept) begin
            o_word_data <= {o_word_data[imem_pkg::NB_DATA-imem_pkg::NB_BYTE-1:0], i_rx_byte};
        end
    end

endmodule

// ==== src/fetch_stage.sv ====
module fetch_stage (
    input  logic                            i_clock,        // System clock.
    input  logic                            i_reset,        // Synchronous reset, active high.
    input  logic                            i_run,          // Step the PC while high.
    output logic [imem_pkg::NB_ADDRESS-1:0] o_address,      // Address sent to the memory.
    input  logic [imem_pkg::NB_DATA-1:0]    i_data,         // Word read at o_address.
    output logic [imem_pkg::NB_ADDRESS-1:0] o_pc,           // PC of the presented instruction.
    output logic [imem_pkg::NB_DATA-1:0]    o_instruction,  // Presented instruction word.
    output logic                            o_fetch_valid,  // Outputs hold a fresh fetch.
    output logic                            o_is_rtype,     // Word is register-register.
    output logic [imem_pkg::NB_REG-1:0]     o_source_reg,   // The rs field.
    output logic [imem_pkg::NB_REG-1:0]     o_dest_reg,     // rd for R-type, rt for I-type.
    output logic [imem_pkg::NB_DATA-1:0]    o_immediate     // Sign-extended immediate.
);

    logic [imem_pkg::NB_ADDRESS-1:0] pc;                    // Address of the next fetch.
    imem_pkg::instruction_t          instruction_q;         // Fetched word, open to both views.
    logic [imem_pkg::NB_IMM-1:0]     immediate_field;       // Raw 16-bit immediate.

    assign o_address = pc;                                  // The memory is read at the PC.

    // PC and valid flag.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc            <= '0;                            // Execution starts at word 0.
            o_fetch_valid <= 1'b0;                          // Nothing fetched yet.
        end else begin
            o_fetch_valid <= i_run;                         // Valid only for a run cycle.
            if (i_run) begin
                pc <= pc + 1'b1;                            // Modulo 256 through natural wrap.
            end
        end
    end

    // Fetch register, the word and its PC are captured together.
    always_ff @(posedge i_clock) begin
        if (i_run) begin
            instruction_q <= i_data;                        // Word at the current PC.
            o_pc          <= pc;                            // PC that the word came from.
        end
    end

    assign o_instruction = instruction_q;                   // Raw word for the next stage.

    // Opcode zero means the R view is the right one.
    assign o_is_rtype    = (instruction_q.r.opcode == imem_pkg::OPCODE_RTYPE);

    assign o_source_reg  = instruction_q.r.rs;              // Same position in both layouts.

    // R-type writes rd, I-type writes rt.
    assign o_dest_reg    = o_is_rtype ? instruction_q.r.rd : instruction_q.i.rt;

    assign immediate_field = instruction_q.i.immediate;     // Low half of the word.

    // Replicate the sign bit into the upper half.
    assign o_immediate = {{(imem_pkg::NB_DATA - imem_pkg::NB_IMM){immediate_field[imem_pkg::NB_IMM-1]}},
                          immediate_field};

endmodule

// ==== src/imem_pkg.sv ====
package imem_pkg;

    localparam int NB_DATA        = 32;                   // Width of one instruction word.
    localparam int RAM_DEPTH      = 256;                  // Number of instruction memory entries.
    localparam int NB_ADDRESS     = 8;                    // Word address width, enough for 256 entries.
    localparam int NB_BYTE        = 8;                    // Width of one byte from the host.
    localparam int BYTES_PER_WORD = 4;                    // Bytes packed into each instruction word.
    localparam int NB_REG         = 5;                    // Register index width, 32 registers.
    localparam int NB_IMM         = 16;                   // Immediate field width of I-type words.

    // Byte counter width inside the assembler and the index of the final byte.
    localparam int NB_BYTE_COUNT = $clog2(BYTES_PER_WORD);        // Two bits count 0 to 3.
    localparam logic [NB_BYTE_COUNT-1:0] LAST_BYTE_INDEX =
        NB_BYTE_COUNT'(BYTES_PER_WORD - 1);                       // Count value of the last byte.

    localparam logic [5:0] OPCODE_RTYPE = 6'd0;           // All register-register ops share opcode 0.

    // Register-register layout, the operation is selected by funct.
    typedef struct packed {
        logic [5:0]        opcode;                        // Primary opcode, zero here.
        logic [NB_REG-1:0] rs;                            // First source register.
        logic [NB_REG-1:0] rt;                            // Second source register.
        logic [NB_REG-1:0] rd;                            // Destination register.
        logic [4:0]        shamt;                         // Shift amount for shift ops.
        logic [5:0]        funct;                         // ALU function select.
    } rtype_t;

    // Immediate layout, used by loads, stores, branches and ALU immediates.
    typedef struct packed {
        logic [5:0]        opcode;                        // Primary opcode, nonzero here.
        logic [NB_REG-1:0] rs;                            // Base or source register.
        logic [NB_REG-1:0] rt;                            // Destination for ALU and load ops.
        logic [NB_IMM-1:0] immediate;                     // Signed 16-bit constant or offset.
    } itype_t;

    // The same fetched word viewed either way, the opcode decides which view applies.
    typedef union packed {
        rtype_t r;                                        // View as a register-register op.
        itype_t i;                                        // View as an immediate op.
    } instruction_t;

endpackage

// ==== src/instruction_memory.sv ====
module instruction_memory (
    input  logic                            i_clock,            // System clock.
    input  logic                            i_reset,            // Synchronous reset, active high.
    input  logic                            i_write_enable,     // Load level, its rising edge restarts at 0.
    input  logic [imem_pkg::NB_DATA-1:0]    i_write_data,       // Word to store.
    input  logic                            i_write_data_next,  // Pulse that stores one word.
    input  logic [imem_pkg::NB_ADDRESS-1:0] i_address,          // Fetch address.
    output logic [imem_pkg::NB_DATA-1:0]    o_data              // Word at i_address.
);

    logic [imem_pkg::NB_DATA-1:0]    memory [imem_pkg::RAM_DEPTH];  // Instruction storage.
    logic [imem_pkg::NB_ADDRESS-1:0] write_address;                 // Next entry to fill.
    logic                            write_enable_q;                // Registered load level.
    logic                            load_start;                    // Load level just went high.
    logic                            write_strobe;                  // Store a word this cycle.

    assign load_start   = i_write_enable && !write_enable_q;

    // The registered level keeps the last word of a load even when the level drops early.
    assign write_strobe = write_enable_q && i_write_data_next;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            write_enable_q <= 1'b0;                     // Forget any load in progress.
        end else begin
            write_enable_q <= i_write_enable;           // One cycle behind the input level.
        end
    end

    // Write pointer, it restarts one cycle after the load level rises.
    always_ff @(posedge i_clock) begin
        if (i_reset || load_start) begin
            write_address <= '0;                        // Every program begins at address 0.
        end else if (write_strobe) begin
            write_address <= write_address + 1'b1;      // Wraps after entry 255.
        end
    end

    // Storage. Entry 0 is cleared so a fetch after reset reads a known word.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            memory[0] <= '0;                            // Known word at the reset PC.
        end else if (write_strobe) begin
            memory[write_address] <= i_write_data;      // Store at the current pointer.
        end
    end

    assign o_data = memory[i_address];                  // Combinational read port.

endmodule

// ==== src/program_loader_top.sv ====
module program_loader_top (
    input  logic                            i_clock,        // System clock.
    input  logic                            i_reset,        // Synchronous reset, active high.
    input  logic                            i_load_enable,  // High while a program is sent.
    input  logic [imem_pkg::NB_BYTE-1:0]    i_rx_byte,      // Program byte from the host.
    input  logic                            i_rx_valid,     // Strobe for i_rx_byte.
    input  logic                            i_run,          // Fetch while high.
    output logic [imem_pkg::NB_ADDRESS-1:0] o_pc,           // PC of the presented instruction.
    output logic [imem_pkg::NB_DATA-1:0]    o_instruction,  // Presented instruction word.
    output logic                            o_fetch_valid,  // Outputs hold a fresh fetch.
    output logic                            o_is_rtype,     // Word is register-register.
    output logic [imem_pkg::NB_REG-1:0]     o_source_reg,   // Decoded rs.
    output logic [imem_pkg::NB_REG-1:0]     o_dest_reg,     // Decoded destination.
    output logic [imem_pkg::NB_DATA-1:0]    o_immediate     // Sign-extended immediate.
);

    logic [imem_pkg::NB_DATA-1:0]    word_data;             // Assembled word to store.
    logic                            word_next;             // Store pulse for word_data.
    logic [imem_pkg::NB_ADDRESS-1:0] fetch_address;         // Read address from the PC.
    logic [imem_pkg::NB_DATA-1:0]    fetch_data;            // Word at fetch_address.

    // Byte stream to words.
    byte_word_assembler u_byte_word_assembler (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_load_enable (i_load_enable),
        .i_rx_byte     (i_rx_byte),
        .i_rx_valid    (i_rx_valid),
        .o_word_data   (word_data),
        .o_word_next   (word_next)
    );

    // Program storage, loaded and fetched at the same time if needed.
    instruction_memory u_instruction_memory (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_write_enable    (i_load_enable),
        .i_write_data      (word_data),
        .i_write_data_next (word_next),
        .i_address         (fetch_address),
        .o_data            (fetch_data)
    );

    // PC, fetch register and field decode.
    fetch_stage u_fetch_stage (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_run         (i_run),
        .o_address     (fetch_address),
        .i_data        (fetch_data),
        .o_pc          (o_pc),
        .o_instruction (o_instruction),
        .o_fetch_valid (o_fetch_valid),
        .o_is_rtype    (o_is_rtype),
        .o_source_reg  (o_source_reg),
        .o_dest_reg    (o_dest_reg),
        .o_immediate   (o_immediate)
    );

endmodule

// ==== verif/loader_properties.sv ====
module loader_properties (
    input logic                            i_clock,        // System clock of the bound top level.
    input logic                            i_reset,        // Synchronous reset, active high.
    input logic                            i_run,          // Run level into the fetch stage.
    input logic                            i_fetch_valid,  // Fetch outputs hold a fresh word.
    input logic [imem_pkg::NB_ADDRESS-1:0] i_pc,           // PC of the presented instruction.
    input logic                            i_word_next     // Write strobe from the assembler.
);

    logic [imem_pkg::NB_ADDRESS-1:0] pc_plus_one;          // Presented PC plus one, wraps at 256.

    assign pc_plus_one = i_pc + 1'b1;

    // A word needs four byte strobes, so the write strobe can never last two cycles.
    word_next_single_pulse: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_word_next |=> !i_word_next
    ) else $error("Write strobe stayed high on two consecutive cycles.");

    // Back-to-back run cycles present consecutive PC values.
    pc_steps_by_one: assert property (
        @(posedge i_clock) disable iff (i_reset)
        (i_fetch_valid && i_run) |=> (i_pc == $past(pc_plus_one))
    ) else $error("PC did not advance by exactly one during a run.");

    // Reset drops the valid flag at the next edge.
    valid_low_after_reset: assert property (
        @(posedge i_clock)
        i_reset |=> !i_fetch_valid
    ) else $error("Fetch valid was high in the cycle after reset.");

endmodule

// Attach the checks to every instance of the top level.
bind program_loader_top loader_properties u_loader_properties (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_run         (i_run),
    .i_fetch_valid (o_fetch_valid),
    .i_pc          (o_pc),
    .i_word_next   (word_next)
);

// ==== verif/tb_program_loader.sv ====
module tb_program_loader;

    // Budget per test: resets 20, first load 100, three advances of 256, hold and wrap 280.
    localparam int TEST_CYCLES    = 2000;                 // Rounded up sum of all tests.
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;      // Generous limit on the whole run.

    logic                            i_clock;             // Clock, 40 time units per period.
    logic                            i_reset;             // Synchronous reset, active high.
    logic                            i_load_enable;       // Load window level.
    logic [imem_pkg::NB_BYTE-1:0]    i_rx_byte;           // Program byte.
    logic                            i_rx_valid;          // Byte strobe.
    logic                            i_run;               // Fetch level.
    logic [imem_pkg::NB_ADDRESS-1:0] o_pc;                // Presented PC.
    logic [imem_pkg::NB_DATA-1:0]    o_instruction;       // Presented word.
    logic                            o_fetch_valid;       // Fresh fetch flag.
    logic                            o_is_rtype;          // Decoded R-type flag.
    logic [imem_pkg::NB_REG-1:0]     o_source_reg;        // Decoded rs.
    logic [imem_pkg::NB_REG-1:0]     o_dest_reg;          // Decoded destination.
    logic [imem_pkg::NB_DATA-1:0]    o_immediate;         // Decoded immediate.

    integer                          seed = 32'h2688;     // Seed for all random stimulus.
    int                              error_count = 0;     // Failed checks so far.
    int                              check_count = 0;     // Checks done so far.
    int                              cycle_count = 0;     // Clock edges since time zero.
    int                              known_words = 0;     // Entries whose content is modeled.
    logic [imem_pkg::NB_ADDRESS-1:0] model_pc;            // Expected address of the next fetch.
    logic [imem_pkg::NB_DATA-1:0]    expected_memory [imem_pkg::RAM_DEPTH];  // Memory model.
    logic [imem_pkg::NB_DATA-1:0]    staged_words [$];    // Words waiting to be sent.

    program_loader_top dut_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_load_enable (i_load_enable),
        .i_rx_byte     (i_rx_byte),
        .i_rx_valid    (i_rx_valid),
        .i_run         (i_run),
        .o_pc          (o_pc),
        .o_instruction (o_instruction),
        .o_fetch_valid (o_fetch_valid),
        .o_is_rtype    (o_is_rtype),
        .o_source_reg  (o_source_reg),
        .o_dest_reg    (o_dest_reg),
        .o_immediate   (o_immediate)
    );

    always #20 i_clock = ~i_clock;                        // Half period of 20.

    // Stops a run that never reaches its end.
    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge i_clock);
        #2;                                               // Outputs settled, inputs may change.
    endtask

    task automatic check_word(input string name, input logic [imem_pkg::NB_DATA-1:0] actual,
                              input logic [imem_pkg::NB_DATA-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_pc(input string name, input logic [imem_pkg::NB_ADDRESS-1:0] actual,
                            input logic [imem_pkg::NB_ADDRESS-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_reg(input string name, input logic [imem_pkg::NB_REG-1:0] actual,
                             input logic [imem_pkg::NB_REG-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // Random word, about half of them forced to the R-type opcode.
    function automatic logic [imem_pkg::NB_DATA-1:0] random_instruction();
        imem_pkg::instruction_t word;
        logic [31:0]            choice;
        word   = $random(seed);
        choice = $random(seed);
        if (choice[0]) begin
            word.r.opcode = imem_pkg::OPCODE_RTYPE;
        end
        return word;
    endfunction

    // Expected decode of one word from its field layout.
    task automatic check_decode(input imem_pkg::instruction_t word);
        logic                          is_r;
        logic [imem_pkg::NB_REG-1:0]   dest;
        logic signed [imem_pkg::NB_DATA-1:0] imm_ext;
        is_r    = (word.r.opcode == imem_pkg::OPCODE_RTYPE);
        dest    = is_r ? word.r.rd : word.i.rt;
        imm_ext = $signed({word.i.immediate, {(imem_pkg::NB_DATA - imem_pkg::NB_IMM){1'b0}}})
                  >>> (imem_pkg::NB_DATA - imem_pkg::NB_IMM);   // Arithmetic shift extends sign.
        check_bit("o_is_rtype", o_is_rtype, is_r);
        check_reg("o_source_reg", o_source_reg, word.r.rs);
        check_reg("o_dest_reg", o_dest_reg, dest);
        check_word("o_immediate", o_immediate, imm_ext);
    endtask

    task automatic do_reset();
        i_reset       = 1'b1;
        i_run         = 1'b0;
        i_load_enable = 1'b0;
        i_rx_valid    = 1'b0;
        repeat (10) next_cycle();
        i_reset          = 1'b0;
        model_pc         = '0;                            // PC restarts at word 0.
        expected_memory[0] = '0;                          // Entry 0 is cleared by reset.
        if (known_words < 1) begin
            known_words = 1;
        end
    endtask

    // One run cycle. The PC and, where the content is modeled, the word and its decode.
    task automatic check_fetch();
        imem_pkg::instruction_t expected_word;
        i_run = 1'b1;
        next_cycle();
        check_bit("o_fetch_valid", o_fetch_valid, 1'b1);
        check_pc("o_pc", o_pc, model_pc);
        if (int'(model_pc) < known_words) begin
            expected_word = expected_memory[model_pc];
            check_word("o_instruction", o_instruction, expected_word);
            check_decode(expected_word);
        end
        model_pc = model_pc + 1'b1;
    endtask

    task automatic stop_run();
        i_run = 1'b0;
        next_cycle();
        check_bit("o_fetch_valid", o_fetch_valid, 1'b0);
    endtask

    task automatic advance_to(input logic [imem_pkg::NB_ADDRESS-1:0] target);
        while (model_pc != target) begin
            check_fetch();                                // At most 255 steps.
        end
    endtask

    // Sends the staged words big-endian, with up to max_gap idle cycles after a byte.
    task automatic load_staged(input int max_gap);
        logic [imem_pkg::NB_DATA-1:0] word;
        int                           gap;
        int                           serial;
        serial        = 0;
        i_load_enable = 1'b1;
        repeat (2) next_cycle();                          // Bytes start two cycles after the rise.
        for (int w = 0; w < staged_words.size(); w++) begin
            word = staged_words[w];
            for (int b = 0; b < imem_pkg::BYTES_PER_WORD; b++) begin
                i_rx_byte  = word[imem_pkg::NB_DATA - 1 - imem_pkg::NB_BYTE * b -: imem_pkg::NB_BYTE];
                i_rx_valid = 1'b1;
                next_cycle();
                gap = (max_gap == 0) ? 0 : serial % (max_gap + 1);
                serial++;
                if (gap > 0) begin
                    i_rx_valid = 1'b0;
                    repeat (gap) next_cycle();
                end
            end
            expected_memory[w] = word;                    // Each load starts at address 0.
        end
        i_rx_valid = 1'b0;
        repeat (2) next_cycle();                          // Strobe, then the last write.
        i_load_enable = 1'b0;
        next_cycle();
        if (staged_words.size() > known_words) begin
            known_words = staged_words.size();
        end
        staged_words.delete();
    endtask

    task automatic send_ignored_bytes(input int count);
        logic [31:0] value;
        i_load_enable = 1'b0;
        for (int k = 0; k < count; k++) begin
            value      = $random(seed);
            i_rx_byte  = value[imem_pkg::NB_BYTE-1:0];
            i_rx_valid = 1'b1;
            next_cycle();
        end
        i_rx_valid = 1'b0;
        next_cycle();
    endtask

    task automatic test_reset_state();
        do_reset();
        check_bit("o_fetch_valid", o_fetch_valid, 1'b0);
        next_cycle();
        check_bit("o_fetch_valid", o_fetch_valid, 1'b0);  // Still idle with run low.
        check_fetch();                                    // PC 0 shows the cleared word.
        stop_run();
    endtask

    task automatic test_load_and_fetch();
        do_reset();
        repeat (16) staged_words.push_back(random_instruction());
        load_staged(0);
        repeat (16) check_fetch();
        stop_run();
    endtask

    // The second load restarts at 0 and leaves entries 4 to 15 alone.
    task automatic test_restart_at_zero();
        repeat (4) staged_words.push_back(random_instruction());
        load_staged(0);
        advance_to('0);
        repeat (16) check_fetch();
        stop_run();
    endtask

    task automatic test_gaps_and_ignored();
        repeat (4) staged_words.push_back(random_instruction());
        load_staged(2);
        send_ignored_bytes(8);                            // Must not write or shift the pointer.
        advance_to('0);
        repeat (16) check_fetch();
        stop_run();
    endtask

    task automatic test_decode();
        imem_pkg::instruction_t word;
        word = '0;                                        // add r30, r17, r9
        word.r.opcode = imem_pkg::OPCODE_RTYPE;
        word.r.rs     = 5'd17;
        word.r.rt     = 5'd9;
        word.r.rd     = 5'd30;
        word.r.funct  = 6'h20;
        staged_words.push_back(word);
        word = '0;                                        // lw r8, -16(r29)
        word.i.opcode    = 6'h23;
        word.i.rs        = 5'd29;
        word.i.rt        = 5'd8;
        word.i.immediate = 16'hfff0;
        staged_words.push_back(word);
        word = '0;                                        // addi r2, r1, 32767
        word.i.opcode    = 6'h08;
        word.i.rs        = 5'd1;
        word.i.rt        = 5'd2;
        word.i.immediate = 16'h7fff;
        staged_words.push_back(word);
        word = '0;                                        // sll r12, r4, 31
        word.r.opcode = imem_pkg::OPCODE_RTYPE;
        word.r.rt     = 5'd4;
        word.r.rd     = 5'd12;
        word.r.shamt  = 5'd31;
        staged_words.push_back(word);
        load_staged(0);
        advance_to('0);
        repeat (4) check_fetch();
        stop_run();
    endtask

    task automatic test_hold_and_wrap();
        logic [imem_pkg::NB_ADDRESS-1:0] held_pc;
        logic [imem_pkg::NB_ADDRESS-1:0] last_pc;
        logic                            wrapped;
        repeat (3) check_fetch();
        held_pc = model_pc - 1'b1;                        // Last PC that was presented.
        i_run   = 1'b0;
        repeat (4) begin
            next_cycle();
            check_bit("o_fetch_valid", o_fetch_valid, 1'b0);
            check_pc("o_pc", o_pc, held_pc);              // Outputs freeze while stopped.
        end
        check_fetch();                                    // Resumes right after the held PC.
        wrapped = 1'b0;
        repeat (imem_pkg::RAM_DEPTH + 4) begin
            last_pc = o_pc;
            check_fetch();
            if (last_pc == 8'hff && o_pc == 8'h00) begin
                wrapped = 1'b1;
            end
        end
        if (!wrapped) begin
            error_count++;
            $display("The PC never wrapped from 255 to 0 during a long run.");
        end
        stop_run();
    endtask

    initial begin
        i_clock       = 1'b0;
        i_reset       = 1'b1;
        i_load_enable = 1'b0;
        i_rx_byte     = '0;
        i_rx_valid    = 1'b0;
        i_run         = 1'b0;
        model_pc      = '0;
        test_reset_state();
        test_load_and_fetch();
        test_restart_at_zero();
        test_gaps_and_ignored();
        test_decode();
        test_hold_and_wrap();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/imem_pkg.sv
src/byte_word_assembler.sv
src/instruction_memory.sv
src/fetch_stage.sv
src/program_loader_top.sv
verif/loader_properties.sv
verif/tb_program_loader.sv
